// File: logic/router_pkg.sv
package router_pkg;

    ////////////////////////////////////////////////////////////////////
    // stream line layout
    ////////////////////////////////////////////////////////////////////
    localparam int LINE_W = 36;
    localparam int PAYLOAD_W = 32;
    localparam int FLAGS_W = 4;

    // flag bits sit directly above the payload
    localparam int SOF_BIT = 32;
    localparam int EOF_BIT = 33;

    ////////////////////////////////////////////////////////////////////
    // inspector
    ////////////////////////////////////////////////////////////////////
    // padded eth + ip + udp + vrt header
    localparam int HDR_LINES = 12;
    localparam int HDR_CNT_W = 4;
    localparam int DSP_START_LINE = 11;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] PROTO_UDP = 8'h11;
    localparam logic [15:0] UDP_DATA_PORT = 16'd49153;

    localparam logic [1:0] INSP_ST_WAIT_SOF = 2'd0;
    localparam logic [1:0] INSP_ST_BUFFER = 2'd1;
    localparam logic [1:0] INSP_ST_REPLAY = 2'd2;
    localparam logic [1:0] INSP_ST_LIVE = 2'd3;

    ////////////////////////////////////////////////////////////////////
    // framer
    ////////////////////////////////////////////////////////////////////
    localparam int BUF_ADDR_W = 9;
    localparam logic [15:0] FRM_HDR_TAG = 16'h0001;

    localparam logic [1:0] FRM_ST_WAIT_SOF = 2'd0;
    localparam logic [1:0] FRM_ST_WAIT_EOF = 2'd1;
    localparam logic [1:0] FRM_ST_HDR = 2'd2;
    localparam logic [1:0] FRM_ST_PAYLOAD = 2'd3;

    // one line seen either as data or as the framer header
    typedef union packed {
        struct packed {
            logic [FLAGS_W-1:0] flags;
            logic [PAYLOAD_W-1:0] payload;
        } data;
        struct packed {
            logic [FLAGS_W-1:0] flags;
            logic [15:0] tag;
            logic [15:0] byte_cnt;
        } hdr;
    } stream_line_u;

endpackage

// File: logic/com_inspector.sv
module com_inspector (
    input  logic                          stream_clk,
    input  logic                          stream_rst,

    input  router_pkg::stream_line_u      com_inp_data_i,
    input  logic                          com_inp_valid_i,
    output logic                          com_inp_ready_o,

    output logic [router_pkg::LINE_W-1:0] cpu_out_data_o,
    output logic                          cpu_out_valid_o,
    input  logic                          cpu_out_ready_i,

    output logic [router_pkg::LINE_W-1:0] dsp_out_data_o,
    output logic                          dsp_out_valid_o,
    input  logic                          dsp_out_ready_i
);

    logic [1:0] state_q;
    logic [router_pkg::HDR_CNT_W-1:0] cnt_q;
    logic dest_dsp_q;

    // header line buffer
    router_pkg::stream_line_u hdr_q [router_pkg::HDR_LINES];

    router_pkg::stream_line_u replay_line;
    router_pkg::stream_line_u out_line;
    logic out_valid;
    logic out_ready;
    logic inp_fire;
    logic out_fire;
    logic last_hdr;
    logic is_dsp;
    logic hdr_we;

    ////////////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////////////
    assign last_hdr = (cnt_q == router_pkg::HDR_CNT_W'(router_pkg::HDR_LINES - 1));

    // ipv4, udp, data port, and a non-zero vrt header on the live line
    assign is_dsp = last_hdr
        && (hdr_q[3].data.payload[15:0] == router_pkg::ETHERTYPE_IPV4)
        && (hdr_q[6].data.payload[23:16] == router_pkg::PROTO_UDP)
        && (hdr_q[9].data.payload[15:0] == router_pkg::UDP_DATA_PORT)
        && (com_inp_data_i.data.payload != '0);

    ////////////////////////////////////////////////////////////////////
    // output steering
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        replay_line = hdr_q[cnt_q];
        // first dsp line becomes the start of the outgoing frame
        if (dest_dsp_q && cnt_q == router_pkg::HDR_CNT_W'(router_pkg::DSP_START_LINE)) begin
            replay_line.data.flags = '0;
            replay_line[router_pkg::SOF_BIT] = 1'b1;
            // keep eof so a frame ending here still closes
            replay_line[router_pkg::EOF_BIT] = hdr_q[cnt_q][router_pkg::EOF_BIT];
        end
    end

    assign out_line = (state_q == router_pkg::INSP_ST_REPLAY) ? replay_line : com_inp_data_i;
    assign out_valid = (state_q == router_pkg::INSP_ST_REPLAY)
        || (state_q == router_pkg::INSP_ST_LIVE && com_inp_valid_i);
    assign out_ready = dest_dsp_q ? dsp_out_ready_i : cpu_out_ready_i;

    assign cpu_out_data_o = out_line;
    assign dsp_out_data_o = out_line;
    assign cpu_out_valid_o = out_valid && !dest_dsp_q;
    assign dsp_out_valid_o = out_valid && dest_dsp_q;

    // always accept while buffering, follow the destination when live
    assign com_inp_ready_o = (state_q == router_pkg::INSP_ST_WAIT_SOF)
        || (state_q == router_pkg::INSP_ST_BUFFER)
        || (state_q == router_pkg::INSP_ST_LIVE && out_ready);

    assign inp_fire = com_inp_valid_i && com_inp_ready_o;
    assign out_fire = out_valid && out_ready;

    assign hdr_we = inp_fire && ((state_q == router_pkg::INSP_ST_BUFFER)
        || (state_q == router_pkg::INSP_ST_WAIT_SOF && com_inp_data_i[router_pkg::SOF_BIT]));

    always_ff @(posedge stream_clk) begin
        if (hdr_we) begin
            hdr_q[cnt_q] <= com_inp_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state_q <= router_pkg::INSP_ST_WAIT_SOF;
            cnt_q <= '0;
            dest_dsp_q <= 1'b0;
        end else begin
            case (state_q)
                router_pkg::INSP_ST_WAIT_SOF: begin
                    if (inp_fire && com_inp_data_i[router_pkg::SOF_BIT]) begin
                        if (com_inp_data_i[router_pkg::EOF_BIT]) begin
                            // single line frame goes straight to the cpu
                            dest_dsp_q <= 1'b0;
                            state_q <= router_pkg::INSP_ST_REPLAY;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                            state_q <= router_pkg::INSP_ST_BUFFER;
                        end
                    end
                end
                router_pkg::INSP_ST_BUFFER: begin
                    if (inp_fire) begin
                        if (is_dsp) begin
                            dest_dsp_q <= 1'b1;
                            cnt_q <= router_pkg::HDR_CNT_W'(router_pkg::DSP_START_LINE);
                            state_q <= router_pkg::INSP_ST_REPLAY;
                        end else if (com_inp_data_i[router_pkg::EOF_BIT] || last_hdr) begin
                            dest_dsp_q <= 1'b0;
                            cnt_q <= '0;
                            state_q <= router_pkg::INSP_ST_REPLAY;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                router_pkg::INSP_ST_REPLAY: begin
                    if (out_fire) begin
                        if (out_line[router_pkg::EOF_BIT]) begin
                            cnt_q <= '0;
                            state_q <= router_pkg::INSP_ST_WAIT_SOF;
                        end else if (last_hdr) begin
                            cnt_q <= '0;
                            state_q <= router_pkg::INSP_ST_LIVE;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (out_fire && out_line[router_pkg::EOF_BIT]) begin
                        state_q <= router_pkg::INSP_ST_WAIT_SOF;
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/dsp_framer.sv
module dsp_framer (
    input  logic                          stream_clk,
    input  logic                          stream_rst,

    input  logic [router_pkg::LINE_W-1:0] dsp_inp_data_i,
    input  logic                          dsp_inp_valid_i,
    output logic                          dsp_inp_ready_o,

    output router_pkg::stream_line_u      frm_data_o,
    output logic                          frm_valid_o,
    input  logic                          frm_ready_i
);

    logic [1:0] state_q;
    logic [router_pkg::BUF_ADDR_W-1:0] addr_q;
    logic [router_pkg::BUF_ADDR_W-1:0] line_cnt_q;

    // payload store, flags are rebuilt on the way out
    logic [router_pkg::PAYLOAD_W-1:0] mem [2**router_pkg::BUF_ADDR_W];
    logic [router_pkg::PAYLOAD_W-1:0] rd_q;
    logic [router_pkg::BUF_ADDR_W-1:0] rd_addr;

    logic inp_fire;
    logic frm_fire;
    logic mem_we;
    logic last_line;
    logic is_sof;
    logic is_eof;

    assign is_sof = dsp_inp_data_i[router_pkg::SOF_BIT];
    assign is_eof = dsp_inp_data_i[router_pkg::EOF_BIT];

    assign dsp_inp_ready_o = (state_q == router_pkg::FRM_ST_WAIT_SOF)
        || (state_q == router_pkg::FRM_ST_WAIT_EOF);
    assign frm_valid_o = (state_q == router_pkg::FRM_ST_HDR)
        || (state_q == router_pkg::FRM_ST_PAYLOAD);

    assign inp_fire = dsp_inp_valid_i && dsp_inp_ready_o;
    assign frm_fire = frm_valid_o && frm_ready_i;
    assign mem_we = inp_fire && (state_q == router_pkg::FRM_ST_WAIT_EOF || is_sof);
    assign last_line = (addr_q + 1'b1 == line_cnt_q);

    ////////////////////////////////////////////////////////////////////
    // line buffer with registered read
    ////////////////////////////////////////////////////////////////////
    // look ahead one line so the next payload is ready right after a transfer
    assign rd_addr = (state_q == router_pkg::FRM_ST_PAYLOAD && frm_fire) ? addr_q + 1'b1 : addr_q;

    always_ff @(posedge stream_clk) begin
        if (mem_we) begin
            mem[addr_q] <= dsp_inp_data_i[router_pkg::PAYLOAD_W-1:0];
        end
        rd_q <= mem[rd_addr];
    end

    ////////////////////////////////////////////////////////////////////
    // output line, header view or data view
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        frm_data_o = '0;
        if (state_q == router_pkg::FRM_ST_HDR) begin
            frm_data_o.hdr.tag = router_pkg::FRM_HDR_TAG;
            frm_data_o.hdr.byte_cnt = 16'({line_cnt_q, 2'b00});
            frm_data_o[router_pkg::SOF_BIT] = 1'b1;
        end else begin
            frm_data_o.data.payload = rd_q;
            frm_data_o[router_pkg::EOF_BIT] = last_line;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state_q <= router_pkg::FRM_ST_WAIT_SOF;
            addr_q <= '0;
            line_cnt_q <= '0;
        end else begin
            case (state_q)
                router_pkg::FRM_ST_WAIT_SOF: begin
                    if (inp_fire && is_sof) begin
                        if (is_eof) begin
                            line_cnt_q <= router_pkg::BUF_ADDR_W'(1);
                            state_q <= router_pkg::FRM_ST_HDR;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                            state_q <= router_pkg::FRM_ST_WAIT_EOF;
                        end
                    end
                end
                router_pkg::FRM_ST_WAIT_EOF: begin
                    if (inp_fire) begin
                        if (is_eof) begin
                            line_cnt_q <= addr_q + 1'b1;
                            addr_q <= '0;
                            state_q <= router_pkg::FRM_ST_HDR;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                router_pkg::FRM_ST_HDR: begin
                    if (frm_fire) begin
                        state_q <= router_pkg::FRM_ST_PAYLOAD;
                    end
                end
                default: begin
                    if (frm_fire) begin
                        if (last_line) begin
                            addr_q <= '0;
                            state_q <= router_pkg::FRM_ST_WAIT_SOF;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/frame_combiner.sv
module frame_combiner (
    input  logic                          stream_clk,
    input  logic                          stream_rst,

    input  logic [router_pkg::LINE_W-1:0] a_data_i,
    input  logic                          a_valid_i,
    output logic                          a_ready_o,

    input  logic [router_pkg::LINE_W-1:0] b_data_i,
    input  logic                          b_valid_i,
    output logic                          b_ready_o,

    output logic [router_pkg::LINE_W-1:0] out_data_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i
);

    // 0 selects input a, 1 selects input b
    logic busy_q;
    logic grant_q;
    logic last_q;
    logic pick;
    logic sel;
    logic out_fire;

    // round robin when both wait, otherwise whoever is valid
    always_comb begin
        if (a_valid_i && b_valid_i) begin
            pick = !last_q;
        end else begin
            pick = b_valid_i;
        end
    end

    assign sel = busy_q ? grant_q : pick;

    assign out_data_o = sel ? b_data_i : a_data_i;
    assign out_valid_o = sel ? b_valid_i : a_valid_i;
    assign a_ready_o = !sel && out_ready_i;
    assign b_ready_o = sel && out_ready_i;

    assign out_fire = out_valid_o && out_ready_i;

    // lock the grant as soon as a line is offered, so a stalled line stays put
    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            busy_q <= 1'b0;
            grant_q <= 1'b0;
            last_q <= 1'b1;
        end else if (out_fire && out_data_o[router_pkg::EOF_BIT]) begin
            busy_q <= 1'b0;
            last_q <= sel;
        end else if (!busy_q && (a_valid_i || b_valid_i)) begin
            busy_q <= 1'b1;
            grant_q <= pick;
        end
    end

endmodule

// File: logic/packet_router_core.sv
module packet_router_core (
    input  logic                          stream_clk,
    input  logic                          stream_rst,

    // communication input
    input  logic [router_pkg::LINE_W-1:0] com_inp_data_i,
    input  logic                          com_inp_valid_i,
    output logic                          com_inp_ready_o,

    // cpu bound frames
    output logic [router_pkg::LINE_W-1:0] cpu_out_data_o,
    output logic                          cpu_out_valid_o,
    input  logic                          cpu_out_ready_i,

    // dsp bound frames
    output logic [router_pkg::LINE_W-1:0] dsp_out_data_o,
    output logic                          dsp_out_valid_o,
    input  logic                          dsp_out_ready_i,

    // packets returning from the dsp
    input  logic [router_pkg::LINE_W-1:0] dsp_inp_data_i,
    input  logic                          dsp_inp_valid_i,
    output logic                          dsp_inp_ready_o,

    // serdes input
    input  logic [router_pkg::LINE_W-1:0] ser_inp_data_i,
    input  logic                          ser_inp_valid_i,
    output logic                          ser_inp_ready_o,

    // communication output
    output logic [router_pkg::LINE_W-1:0] com_out_data_o,
    output logic                          com_out_valid_o,
    input  logic                          com_out_ready_i
);

    // framer to combiner
    logic [router_pkg::LINE_W-1:0] frm_data;
    logic frm_valid;
    logic frm_ready;

    com_inspector com_inspector_inst (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .com_inp_data_i  (com_inp_data_i),
        .com_inp_valid_i (com_inp_valid_i),
        .com_inp_ready_o (com_inp_ready_o),
        .cpu_out_data_o  (cpu_out_data_o),
        .cpu_out_valid_o (cpu_out_valid_o),
        .cpu_out_ready_i (cpu_out_ready_i),
        .dsp_out_data_o  (dsp_out_data_o),
        .dsp_out_valid_o (dsp_out_valid_o),
        .dsp_out_ready_i (dsp_out_ready_i)
    );

    dsp_framer dsp_framer_inst (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .dsp_inp_data_i  (dsp_inp_data_i),
        .dsp_inp_valid_i (dsp_inp_valid_i),
        .dsp_inp_ready_o (dsp_inp_ready_o),
        .frm_data_o      (frm_data),
        .frm_valid_o     (frm_valid),
        .frm_ready_i     (frm_ready)
    );

    frame_combiner frame_combiner_inst (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .a_data_i    (frm_data),
        .a_valid_i   (frm_valid),
        .a_ready_o   (frm_ready),
        .b_data_i    (ser_inp_data_i),
        .b_valid_i   (ser_inp_valid_i),
        .b_ready_o   (ser_inp_ready_o),
        .out_data_o  (com_out_data_o),
        .out_valid_o (com_out_valid_o),
        .out_ready_i (com_out_ready_i)
    );

endmodule

// File: verif/packet_router_core_checker.sv
module packet_router_core_checker (
    input  logic                          stream_clk,
    input  logic                          stream_rst,

    input  logic [router_pkg::LINE_W-1:0] cpu_data_i,
    input  logic                          cpu_valid_i,
    input  logic                          cpu_ready_i,

    input  logic [router_pkg::LINE_W-1:0] dsp_data_i,
    input  logic                          dsp_valid_i,
    input  logic                          dsp_ready_i,

    input  logic [router_pkg::LINE_W-1:0] com_data_i,
    input  logic                          com_valid_i,
    input  logic                          com_ready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic in_frame_q;
    int fail_cnt = 0;

    // open frame on com_out, set by sof and cleared by eof
    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            in_frame_q <= 1'b0;
        end else if (com_valid_i && com_ready_i) begin
            if (com_data_i[router_pkg::EOF_BIT]) begin
                in_frame_q <= 1'b0;
            end else if (com_data_i[router_pkg::SOF_BIT]) begin
                in_frame_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stalled lines hold
    //////////////////////////////////////////////////////////////////////
    cpu_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        cpu_valid_i && !cpu_ready_i |=> cpu_valid_i && $stable(cpu_data_i))
        else begin
            fail_cnt++;
            $error("cpu_out changed or dropped a stalled line");
        end

    dsp_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        dsp_valid_i && !dsp_ready_i |=> dsp_valid_i && $stable(dsp_data_i))
        else begin
            fail_cnt++;
            $error("dsp_out changed or dropped a stalled line");
        end

    com_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        com_valid_i && !com_ready_i |=> com_valid_i && $stable(com_data_i))
        else begin
            fail_cnt++;
            $error("com_out changed or dropped a stalled line");
        end

    // quiet outputs while reset is held
    rst_quiet: assert property (@(posedge stream_clk)
        stream_rst && $past(stream_rst) |-> !(cpu_valid_i || dsp_valid_i || com_valid_i))
        else begin
            fail_cnt++;
            $error("an output is valid during reset");
        end

    com_frames: assert property (@(posedge stream_clk) disable iff (stream_rst)
        com_valid_i && com_ready_i && com_data_i[router_pkg::SOF_BIT] |-> !in_frame_q)
        else begin
            fail_cnt++;
            $error("com_out started a frame inside another");
        end

endmodule

bind packet_router_core packet_router_core_checker checker_inst (
    .stream_clk  (stream_clk),
    .stream_rst  (stream_rst),
    .cpu_data_i  (cpu_out_data_o),
    .cpu_valid_i (cpu_out_valid_o),
    .cpu_ready_i (cpu_out_ready_i),
    .dsp_data_i  (dsp_out_data_o),
    .dsp_valid_i (dsp_out_valid_o),
    .dsp_ready_i (dsp_out_ready_i),
    .com_data_i  (com_out_data_o),
    .com_valid_i (com_out_valid_o),
    .com_ready_i (com_out_ready_i)
);

// File: verif/packet_router_core_tb.sv
module packet_router_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = router_pkg::LINE_W;
    localparam int WAIT_LIMIT = 5000;
    localparam int COM_PORT = 0;
    localparam int DSP_PORT = 1;
    localparam int SER_PORT = 2;
    localparam int SRC_NONE = 0;
    localparam int SRC_FRM = 1;
    localparam int SRC_SER = 2;

    logic stream_clk = 1'b0;
    logic stream_rst;
    logic [W-1:0] com_inp_data;
    logic [W-1:0] dsp_inp_data;
    logic [W-1:0] ser_inp_data;
    logic com_inp_valid;
    logic dsp_inp_valid;
    logic ser_inp_valid;
    logic com_inp_ready;
    logic dsp_inp_ready;
    logic ser_inp_ready;
    logic [W-1:0] cpu_out_data;
    logic [W-1:0] dsp_out_data;
    logic [W-1:0] com_out_data;
    logic cpu_out_valid;
    logic dsp_out_valid;
    logic com_out_valid;
    logic cpu_out_ready = 1'b0;
    logic dsp_out_ready = 1'b0;
    logic com_out_ready = 1'b0;

    // expected lines per output, com_out split by source
    logic [W-1:0] exp_cpu[$];
    logic [W-1:0] exp_dsp[$];
    logic [W-1:0] exp_frm[$];
    logic [W-1:0] exp_ser[$];
    int com_src = SRC_NONE;
    int value_errors = 0;
    int timeouts = 0;
    int checker_fails;
    int seed = 32'h225f_a302;

    packet_router_core packet_router_core_inst (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .com_inp_data_i  (com_inp_data),
        .com_inp_valid_i (com_inp_valid),
        .com_inp_ready_o (com_inp_ready),
        .cpu_out_data_o  (cpu_out_data),
        .cpu_out_valid_o (cpu_out_valid),
        .cpu_out_ready_i (cpu_out_ready),
        .dsp_out_data_o  (dsp_out_data),
        .dsp_out_valid_o (dsp_out_valid),
        .dsp_out_ready_i (dsp_out_ready),
        .dsp_inp_data_i  (dsp_inp_data),
        .dsp_inp_valid_i (dsp_inp_valid),
        .dsp_inp_ready_o (dsp_inp_ready),
        .ser_inp_data_i  (ser_inp_data),
        .ser_inp_valid_i (ser_inp_valid),
        .ser_inp_ready_o (ser_inp_ready),
        .com_out_data_o  (com_out_data),
        .com_out_valid_o (com_out_valid),
        .com_out_ready_i (com_out_ready)
    );

    always #50 stream_clk = ~stream_clk;

    function automatic logic [W-1:0] make_line(input logic sof, input logic eof,
                                                input logic [31:0] payload);
        logic [W-1:0] line;
        line = '0;
        line[31:0] = payload;
        line[router_pkg::SOF_BIT] = sof;
        line[router_pkg::EOF_BIT] = eof;
        return line;
    endfunction

    function automatic void compare_line(input string name, input logic [W-1:0] expected,
                                         input logic [W-1:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endfunction

    function automatic void report_extra(input string name);
        value_errors++;
        $display("%s delivered a line that no sent frame accounts for", name);
    endfunction

    function automatic logic port_ready(input int port);
        case (port)
            COM_PORT: return com_inp_ready;
            DSP_PORT: return dsp_inp_ready;
            default: return ser_inp_ready;
        endcase
    endfunction

    function automatic int pending_lines();
        return exp_cpu.size() + exp_dsp.size() + exp_frm.size() + exp_ser.size();
    endfunction

    task automatic drive_port(input int port, input logic [W-1:0] line, input logic valid);
        case (port)
            COM_PORT: begin
                com_inp_data = line;
                com_inp_valid = valid;
            end
            DSP_PORT: begin
                dsp_inp_data = line;
                dsp_inp_valid = valid;
            end
            default: begin
                ser_inp_data = line;
                ser_inp_valid = valid;
            end
        endcase
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_line(input int port, input logic [W-1:0] line);
        int cycles;
        cycles = 0;
        drive_port(port, line, 1'b1);
        @(posedge stream_clk);
        while (!port_ready(port) && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge stream_clk);
        end
        if (!port_ready(port)) begin
            timeouts++;
            $display("input stream %0d did not accept a line in time", port);
        end
        @(negedge stream_clk);
        drive_port(port, line, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame builders
    //////////////////////////////////////////////////////////////////////
    task automatic send_com_frame(input int n_lines, input logic [15:0] udp_port);
        logic [W-1:0] lines[$];
        logic [31:0] payload;
        logic to_dsp;
        to_dsp = (n_lines >= router_pkg::HDR_LINES) && (udp_port == router_pkg::UDP_DATA_PORT);
        for (int i = 0; i < n_lines; i++) begin
            payload = $random(seed);
            if (i == 3) payload[15:0] = router_pkg::ETHERTYPE_IPV4;
            if (i == 6) payload[23:16] = router_pkg::PROTO_UDP;
            if (i == 9) payload[15:0] = udp_port;
            if (i == 11) payload[0] = 1'b1;
            lines.push_back(make_line(i == 0, i == n_lines - 1, payload));
        end
        // dsp frames start at line 11 with sof as the only new flag
        for (int i = 0; i < n_lines; i++) begin
            if (!to_dsp) begin
                exp_cpu.push_back(lines[i]);
            end else if (i == router_pkg::DSP_START_LINE) begin
                exp_dsp.push_back(make_line(1'b1, i == n_lines - 1, lines[i][31:0]));
            end else if (i > router_pkg::DSP_START_LINE) begin
                exp_dsp.push_back(lines[i]);
            end
        end
        foreach (lines[i]) send_line(COM_PORT, lines[i]);
    endtask

    task automatic send_dsp_packet(input int n_lines);
        logic [31:0] payload;
        exp_frm.push_back(make_line(1'b1, 1'b0,
                                    {router_pkg::FRM_HDR_TAG, 16'(n_lines * 4)}));
        for (int i = 0; i < n_lines; i++) begin
            payload = $random(seed);
            exp_frm.push_back(make_line(1'b0, i == n_lines - 1, payload));
            send_line(DSP_PORT, make_line(i == 0, i == n_lines - 1, payload));
        end
    endtask

    task automatic send_ser_frame(input int n_lines, input int id);
        logic [W-1:0] line;
        for (int i = 0; i < n_lines; i++) begin
            line = make_line(i == 0, i == n_lines - 1, $random(seed));
            // marker on the sof line so it never looks like a framer header
            if (i == 0) line[31:0] = {16'h5E50, 16'(id)};
            exp_ser.push_back(line);
            send_line(SER_PORT, line);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (pending_lines() != 0 && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge stream_clk);
        end
        if (pending_lines() != 0) begin
            timeouts++;
            $display("%0d expected output lines never arrived", pending_lines());
        end
        @(negedge stream_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // back-pressure and output monitors
    //////////////////////////////////////////////////////////////////////
    always @(negedge stream_clk) begin
        if (!stream_rst) begin
            cpu_out_ready = ($random(seed) & 32'd3) != 0;
            dsp_out_ready = ($random(seed) & 32'd3) != 0;
            com_out_ready = ($random(seed) & 32'd3) != 0;
        end
    end

    always @(posedge stream_clk) begin
        if (!stream_rst && cpu_out_valid && cpu_out_ready) begin
            if (exp_cpu.size() == 0) report_extra("cpu_out");
            else compare_line("cpu_out_data_o", exp_cpu.pop_front(), cpu_out_data);
        end
        if (!stream_rst && dsp_out_valid && dsp_out_ready) begin
            if (exp_dsp.size() == 0) report_extra("dsp_out");
            else compare_line("dsp_out_data_o", exp_dsp.pop_front(), dsp_out_data);
        end
        if (!stream_rst && com_out_valid && com_out_ready) begin
            // a sof line tells which source the frame came from
            if (com_out_data[router_pkg::SOF_BIT]) begin
                if (exp_frm.size() != 0 && com_out_data === exp_frm[0]) com_src = SRC_FRM;
                else if (exp_ser.size() != 0 && com_out_data === exp_ser[0]) com_src = SRC_SER;
                else com_src = SRC_NONE;
            end
            if (com_src == SRC_FRM && exp_frm.size() != 0) begin
                compare_line("com_out_data_o", exp_frm.pop_front(), com_out_data);
            end else if (com_src == SRC_SER && exp_ser.size() != 0) begin
                compare_line("com_out_data_o", exp_ser.pop_front(), com_out_data);
            end else begin
                report_extra("com_out");
            end
            if (com_out_data[router_pkg::EOF_BIT]) com_src = SRC_NONE;
        end
    end

    initial begin
        stream_rst = 1'b1;
        com_inp_data = '0;
        com_inp_valid = 1'b0;
        dsp_inp_data = '0;
        dsp_inp_valid = 1'b0;
        ser_inp_data = '0;
        ser_inp_valid = 1'b0;
        repeat (8) @(posedge stream_clk);
        @(negedge stream_clk);
        stream_rst = 1'b0;

        // inspector frames next to a lone dsp packet
        fork
            begin
                send_com_frame(6, router_pkg::UDP_DATA_PORT);
                send_com_frame(20, router_pkg::UDP_DATA_PORT);
                send_com_frame(20, router_pkg::UDP_DATA_PORT + 16'd1);
            end
            send_dsp_packet(5);
        join
        wait_drained();

        // both combiner inputs busy at once
        fork
            begin
                send_dsp_packet(3);
                send_dsp_packet(8);
            end
            begin
                send_ser_frame(4, 1);
                send_ser_frame(6, 2);
                send_ser_frame(1, 3);
            end
        join
        wait_drained();
        repeat (2) @(posedge stream_clk);

        checker_fails = packet_router_core_inst.checker_inst.fail_cnt;
        $display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 value_errors, timeouts, checker_fails);
        if (value_errors + timeouts + checker_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: packet_router_core.f
logic/router_pkg.sv
logic/com_inspector.sv
logic/dsp_framer.sv
logic/frame_combiner.sv
logic/packet_router_core.sv
verif/packet_router_core_checker.sv
verif/packet_router_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = packet_router_core_tb
FILELIST  = packet_router_core.f

BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = all tests passed
SOURCES   = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
